/* common/game_pkg.sv */
`default_nettype none

package game_pkg;

    typedef enum logic [1:0] {
        ST_NEWGAME = 2'd0,
        ST_PLAY    = 2'd1,
        ST_NEWGUN  = 2'd2,
        ST_OVER    = 2'd3
    } state_e;

    typedef struct packed {
        logic left;
        logic right;
        logic fire;
        logic start;
    } keys_t;

    // feeds the seven-segment display
    typedef struct packed {
        logic [3:0] score_hi; // bcd tens
        logic [3:0] score_lo; // bcd units
        logic [1:0] lives;
        logic       game_over;
    } status_t;

    localparam int GUN_Y_T    = 420; // gun rows
    localparam int GUN_Y_B    = 470;
    localparam int GUN_X_SIZE = 50;
    localparam int SHOT_SIZE  = 6;
    localparam int OBS_SIZE   = 30;
    localparam int OBS_Y      = 150; // top row of the obstacles
    localparam int OBS_X0     = 20;  // left edge of obstacle 0
    localparam int OBS_PITCH  = 64;
    localparam int LIVES_INIT = 3;

endpackage

`default_nettype wire

/* common/video_pkg.sv */
`default_nettype none

package video_pkg;

    typedef logic [9:0] coord_t; // one axis of the scan

    localparam int MAX_X = 640; // visible width
    localparam int MAX_Y = 480; // visible height

    // 3-bit colour, one bit per gun of the monitor
    typedef enum logic [2:0] {
        BLACK  = 3'b000,
        BLUE   = 3'b001, // obstacle
        RED    = 3'b100, // shot
        YELLOW = 3'b110, // game-over band
        WHITE  = 3'b111  // gun
    } color_e;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } scan_t;

endpackage

`default_nettype wire

/* dv/shooter_tests.svh */
`ifndef SHOOTER_TESTS_SVH
`define SHOOTER_TESTS_SVH
`default_nettype none

task automatic apply_reset();
    @(posedge clk);
    rst    <= 1'b1;
    scan_i <= PARK_POS;
    keys_i <= KEYS_NONE;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
endtask

task automatic set_keys(input keys_t k);
    @(posedge clk);
    keys_i <= k;
endtask

task automatic press_start();
    @(posedge clk);
    keys_i.start <= 1'b1;
    @(posedge clk);
    keys_i.start <= 1'b0;
endtask

// n back-to-back frame ticks, then the scan moves away
task automatic run_ticks(input int n);
    repeat (n) begin
        @(posedge clk);
        scan_i <= TICK_POS;
    end
    @(posedge clk);
    scan_i <= PARK_POS;
endtask

task automatic fire_shot();
    set_keys(KEYS_FIRE);
    run_ticks(1); // launch tick
    set_keys(KEYS_NONE);
endtask

task automatic probe_pixel(input int x, input int y, input color_e expected);
    scan_t pos;
    pos.x = coord_t'(x);
    pos.y = coord_t'(y);
    @(posedge clk);
    scan_i <= pos;
    @(posedge clk); // rgb registered here
    @(negedge clk);
    compare_value($sformatf("rgb_o at (%0d,%0d)", x, y), int'(rgb_o), int'(expected));
endtask

task automatic expect_status(input int score, input int lives, input int over);
    status_t expected;
    expected.score_hi  = 4'(score / 10);
    expected.score_lo  = 4'(score % 10);
    expected.lives     = 2'(lives);
    expected.game_over = 1'(over);
    @(posedge clk);
    @(negedge clk);
    compare_value("status_o", int'(status_o), int'(expected));
endtask

// which obstacle the shot's column overlaps, -1 for a gap
function automatic int obstacle_at(input int sx);
    int left;
    for (int k = 0; k < N_OBS; k++) begin
        left = OBS_X0 + k * OBS_PITCH;
        if (sx + SHOT_SIZE > left && sx < left + OBS_SIZE) begin
            return k;
        end
    end
    return -1;
endfunction

// ticks after launch until the shot ends on the obstacle row or at the top
function automatic int ticks_to_end(input bit in_column);
    int sy;
    int cnt;
    sy  = GUN_Y_T - SHOT_SIZE;
    cnt = 1;
    while (sy >= SHOT_V
           && !(in_column && sy + SHOT_SIZE > OBS_Y && sy < OBS_Y + OBS_SIZE)) begin
        sy -= SHOT_V;
        cnt++;
    end
    return cnt;
endfunction

task automatic reset_state();
    expect_status(0, LIVES_INIT, 0);
    probe_pixel(300, 440, WHITE);
    probe_pixel(25, 155, BLUE);
    probe_pixel(0, 300, BLACK);
endtask

task automatic gun_movement();
    int n;
    int gx;
    n  = $unsigned($random(seed)) % 128; // sometimes long enough to reach the edge
    gx = GUN_HOME;
    for (int i = 0; i < n; i++) begin
        if (gx + GUN_V + GUN_X_SIZE - 1 <= MAX_X - 1) begin
            gx += GUN_V;
        end
    end
    apply_reset();
    press_start();
    set_keys(KEYS_RIGHT);
    run_ticks(n);
    set_keys(KEYS_NONE);
    probe_pixel(gx, 440, WHITE);
    probe_pixel(gx + GUN_X_SIZE - 1, 440, WHITE);
    probe_pixel(gx - 1, 440, BLACK);
    if (gx + GUN_X_SIZE < MAX_X) begin
        probe_pixel(gx + GUN_X_SIZE, 440, BLACK);
    end
endtask

task automatic shot_flight();
    int sx;
    int sy;
    sx = GUN_HOME + SHOT_DX;
    sy = GUN_Y_T - SHOT_SIZE - 3 * SHOT_V;
    apply_reset();
    press_start();
    fire_shot();
    run_ticks(3);
    probe_pixel(sx, sy, RED);
    probe_pixel(sx + SHOT_SIZE - 1, sy + SHOT_SIZE - 1, RED);
    probe_pixel(sx + SHOT_SIZE, sy, BLACK);
    probe_pixel(sx, sy - 1, BLACK);
endtask

task automatic hit_and_score();
    int gx;
    int steps;
    int k;
    int left;
    gx    = GUN_HOME;
    steps = 0;
    while (obstacle_at(gx + SHOT_DX) < 0 && gx >= GUN_V) begin // steer left
        gx -= GUN_V;
        steps++;
    end
    k    = obstacle_at(gx + SHOT_DX);
    left = OBS_X0 + k * OBS_PITCH;
    if (k < 0) begin
        error_count++;
        $display("error at %0t ns: no gun position lines the shot up with an obstacle", $time);
    end else begin
        apply_reset();
        press_start();
        set_keys(KEYS_LEFT);
        run_ticks(steps);
        fire_shot();
        run_ticks(ticks_to_end(1'b1) - 1);
        expect_status(0, LIVES_INIT, 0);
        probe_pixel(left + 1, OBS_Y + 1, BLUE);
        run_ticks(1); // the hit tick
        expect_status(1, LIVES_INIT, 0);
        probe_pixel(left + 1, OBS_Y + 1, BLACK);
        probe_pixel(OBS_X0 + ((k + 1) % N_OBS) * OBS_PITCH + 1, OBS_Y + 1, BLUE);
    end
endtask

task automatic misses_to_game_over();
    int lives;
    lives = LIVES_INIT;
    apply_reset();
    if (obstacle_at(GUN_HOME + SHOT_DX) >= 0) begin
        error_count++;
        $display("error at %0t ns: the centred gun does not fire into a gap", $time);
    end
    for (int round = 0; round < LIVES_INIT; round++) begin
        press_start();
        fire_shot();
        run_ticks(ticks_to_end(1'b0));
        lives--;
        expect_status(0, lives, int'(lives == 0));
    end
    probe_pixel(100, 200, YELLOW);
    probe_pixel(100, 300, BLACK);
    press_start();
    expect_status(0, LIVES_INIT, 0);
endtask

`default_nettype wire
`endif

/* dv/tb_shooter.sv */
`default_nettype none

module tb_shooter
    import video_pkg::*, game_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 4;
    localparam int N_TESTS         = 5;
    localparam int WATCHDOG_CYCLES = 200 * N_TESTS;
    localparam int GUN_V           = 4;
    localparam int SHOT_V          = 7;
    localparam int N_OBS           = 10;
    localparam int GUN_HOME        = (MAX_X - GUN_X_SIZE) / 2;
    localparam int SHOT_DX         = (GUN_X_SIZE - SHOT_SIZE) / 2; // shot offset from gun edge

    localparam scan_t TICK_POS   = '{x: 10'(MAX_X - 1), y: 10'(MAX_Y - 1)}; // last pixel
    localparam scan_t PARK_POS   = '{x: 10'd0, y: 10'd0};
    localparam keys_t KEYS_NONE  = '0;
    localparam keys_t KEYS_LEFT  = '{left: 1'b1, right: 1'b0, fire: 1'b0, start: 1'b0};
    localparam keys_t KEYS_RIGHT = '{left: 1'b0, right: 1'b1, fire: 1'b0, start: 1'b0};
    localparam keys_t KEYS_FIRE  = '{left: 1'b0, right: 1'b0, fire: 1'b1, start: 1'b0};

    logic    clk;
    logic    rst;
    scan_t   scan_i;
    keys_t   keys_i;
    color_e  rgb_o;
    status_t status_o;
    integer  seed;
    int      error_count;
    int      check_count;

    shooter_top #(.GUN_V(GUN_V), .SHOT_V(SHOT_V), .N_OBS(N_OBS)) i_dut (
        .clk, .rst, .scan_i, .keys_i, .rgb_o, .status_o
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_value(input string name, input int got, input int expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    `include "shooter_tests.svh"

    initial begin : watchdog
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        scan_i      = PARK_POS;
        keys_i      = KEYS_NONE;
        seed        = 32'hde22;
        error_count = 0;
        check_count = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        reset_state();
        gun_movement();
        shot_flight();
        hit_and_score();
        misses_to_game_over();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+dv
common/video_pkg.sv
common/game_pkg.sv
objects/gun_ctrl.sv
objects/shot_ctrl.sv
objects/obstacle_row.sv
verilog/game_fsm.sv
verilog/pixel_mux.sv
verilog/shooter_top.sv
dv/tb_shooter.sv

/* objects/gun_ctrl.sv */
`default_nettype none

module gun_ctrl import video_pkg::*, game_pkg::*; #(
    parameter int GUN_V = 4
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         frame_tick_i,
    input  wire         play_i,
    input  wire keys_t  keys_i,
    input  wire scan_t  scan_i,
    output coord_t      gun_x_o,
    output logic        gun_on_o
);

    localparam coord_t GUN_X_HOME = coord_t'((MAX_X - GUN_X_SIZE) / 2); // centred

    coord_t gun_x_q; // left edge
    logic   step_r;
    logic   step_l;

    assign step_r = keys_i.right && (int'(gun_x_q) + GUN_V + GUN_X_SIZE <= MAX_X);
    assign step_l = keys_i.left && (int'(gun_x_q) >= GUN_V); // stays on screen

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gun_x_q <= GUN_X_HOME;
        end else if (!play_i) begin
            gun_x_q <= GUN_X_HOME; // back to centre between lives
        end else if (frame_tick_i) begin
            if (step_r) begin
                gun_x_q <= gun_x_q + coord_t'(GUN_V);
            end else if (step_l) begin
                gun_x_q <= gun_x_q - coord_t'(GUN_V);
            end
        end
    end

    assign gun_x_o  = gun_x_q;
    assign gun_on_o = (scan_i.x >= gun_x_q) && (int'(scan_i.x) < int'(gun_x_q) + GUN_X_SIZE)
                   && (scan_i.y >= GUN_Y_T) && (scan_i.y <= GUN_Y_B);

endmodule

`default_nettype wire

/* objects/obstacle_row.sv */
`default_nettype none

module obstacle_row import video_pkg::*, game_pkg::*; #(
    parameter int N_OBS = 10
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         frame_tick_i,
    input  wire         play_i,
    input  wire scan_t  shot_pos_i,
    input  wire         shot_live_i,
    input  wire scan_t  scan_i,
    output logic        hit_o,
    output logic        obs_on_o
);

    logic [N_OBS-1:0] alive_q;
    logic [N_OBS-1:0] struck;
    logic [N_OBS-1:0] covered;
    logic             tick;

    assign tick = frame_tick_i && play_i;

    // geometry of obstacle k is fixed, so everything is a compare
    always_comb begin
        int left;
        int sx;
        int sy;
        sx = int'(shot_pos_i.x);
        sy = int'(shot_pos_i.y);
        for (int k = 0; k < N_OBS; k++) begin
            left = OBS_X0 + k * OBS_PITCH;
            struck[k] = alive_q[k] && (sx + SHOT_SIZE > left) && (sx < left + OBS_SIZE)
                     && (sy + SHOT_SIZE > OBS_Y) && (sy < OBS_Y + OBS_SIZE);
            covered[k] = alive_q[k]
                      && (int'(scan_i.x) >= left) && (int'(scan_i.x) < left + OBS_SIZE)
                      && (int'(scan_i.y) >= OBS_Y) && (int'(scan_i.y) < OBS_Y + OBS_SIZE);
        end
    end

    assign hit_o    = tick && shot_live_i && (|struck);
    assign obs_on_o = |covered;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alive_q <= '1;
        end else if (!play_i) begin
            alive_q <= '1;
        end else if (tick) begin
            if (alive_q == '0) begin
                alive_q <= '1; // row cleared, bring it back
            end else if (hit_o) begin
                alive_q <= alive_q & ~struck;
            end
        end
    end

endmodule

`default_nettype wire

/* objects/shot_ctrl.sv */
`default_nettype none

module shot_ctrl import video_pkg::*, game_pkg::*; #(
    parameter int SHOT_V = 7
) (
    input  wire         clk,
    input  wire         rst,
    input  wire         frame_tick_i,
    input  wire         play_i,
    input  wire         fire_i,
    input  wire coord_t gun_x_i,
    input  wire         hit_i,
    input  wire scan_t  scan_i,
    output scan_t       shot_pos_o,
    output logic        shot_live_o,
    output logic        miss_o,
    output logic        shot_on_o
);

    scan_t shot_q;
    logic  live_q;
    logic  tick;
    logic  launch;

    assign tick   = frame_tick_i && play_i;
    assign launch = tick && fire_i && !live_q; // one shot at a time
    assign miss_o = tick && live_q && !hit_i && (int'(shot_q.y) < SHOT_V); // would pass the top

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            live_q <= 1'b0;
        end else if (!play_i) begin
            live_q <= 1'b0;
        end else if (launch) begin
            live_q <= 1'b1;
        end else if (hit_i || miss_o) begin
            live_q <= 1'b0;
        end
    end

    // launch from the gun, then climb
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shot_q <= '0;
        end else if (!play_i) begin
            shot_q <= '0;
        end else if (launch) begin
            shot_q.x <= coord_t'(int'(gun_x_i) + (GUN_X_SIZE - SHOT_SIZE) / 2);
            shot_q.y <= coord_t'(GUN_Y_T - SHOT_SIZE);
        end else if (tick && live_q) begin
            shot_q.y <= shot_q.y - coord_t'(SHOT_V); // climb
        end
    end

    assign shot_pos_o  = shot_q;
    assign shot_live_o = live_q;
    assign shot_on_o   = live_q
                      && (scan_i.x >= shot_q.x) && (int'(scan_i.x) < int'(shot_q.x) + SHOT_SIZE)
                      && (scan_i.y >= shot_q.y) && (int'(scan_i.y) < int'(shot_q.y) + SHOT_SIZE);

    // a hit always belongs to the one shot in flight
    a_one_shot : assert property (@(posedge clk) disable iff (rst)
        hit_i |-> live_q);

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_shooter -f flist.f -o sim_shooter \
    && ./obj_dir/sim_shooter | tee /dev/stderr | grep -qx "TESTS PASSED" \
    || { echo "run.sh: simulation did not pass"; exit 1; }

/* verilog/game_fsm.sv */
`default_nettype none

module game_fsm import video_pkg::*, game_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire scan_t  scan_i,
    input  wire         start_i,
    input  wire         hit_i,
    input  wire         miss_i,
    output logic        frame_tick_o,
    output logic        play_o,
    output status_t     status_o
);

    state_e  state_q;
    state_e  state_d;
    status_t status_q;
    status_t status_d;

    // last visible pixel of the frame
    assign frame_tick_o = (int'(scan_i.x) == MAX_X - 1) && (int'(scan_i.y) == MAX_Y - 1);
    assign play_o       = (state_q == ST_PLAY);

    always_comb begin
        state_d  = state_q;
        status_d = status_q;
        case (state_q)
            ST_NEWGAME: begin
                status_d.score_hi = 4'd0;
                status_d.score_lo = 4'd0;
                status_d.lives    = 2'(LIVES_INIT);
                if (start_i) begin
                    state_d = ST_PLAY;
                end
            end
            ST_PLAY: begin
                if (hit_i) begin // bcd count, 99 wraps to 00
                    if (status_q.score_lo == 4'd9) begin
                        status_d.score_lo = 4'd0;
                        status_d.score_hi = (status_q.score_hi == 4'd9) ? 4'd0
                                          : status_q.score_hi + 4'd1;
                    end else begin
                        status_d.score_lo = status_q.score_lo + 4'd1;
                    end
                end
                if (miss_i) begin
                    status_d.lives = status_q.lives - 2'd1;
                    state_d = (status_q.lives == 2'd1) ? ST_OVER : ST_NEWGUN;
                end
            end
            ST_NEWGUN: begin
                if (start_i) begin
                    state_d = ST_PLAY;
                end
            end
            default: begin // ST_OVER
                if (start_i) begin
                    state_d = ST_NEWGAME;
                end
            end
        endcase
        status_d.game_over = (state_d == ST_OVER);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q  <= ST_NEWGAME;
            status_q <= '{score_hi: 4'd0, score_lo: 4'd0, lives: 2'(LIVES_INIT), game_over: 1'b0};
        end else begin
            state_q  <= state_d;
            status_q <= status_d;
        end
    end

    assign status_o = status_q;

    a_bcd_digits : assert property (@(posedge clk) disable iff (rst)
        hit_i |=> (status_q.score_hi <= 4'd9) && (status_q.score_lo <= 4'd9));

endmodule

`default_nettype wire

/* verilog/pixel_mux.sv */
`default_nettype none

module pixel_mux import video_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         gun_on_i,
    input  wire         shot_on_i,
    input  wire         obs_on_i,
    input  wire         game_over_i,
    input  wire scan_t  scan_i,
    output color_e      rgb_o
);

    color_e rgb_d;
    logic   band_on;

    assign band_on = game_over_i && (scan_i.y >= 10'd192) && (scan_i.y <= 10'd255);

    always_comb begin
        if (shot_on_i) begin
            rgb_d = RED; // shot drawn over everything
        end else if (gun_on_i) begin
            rgb_d = WHITE;
        end else if (obs_on_i) begin
            rgb_d = BLUE;
        end else if (band_on) begin
            rgb_d = YELLOW;
        end else begin
            rgb_d = BLACK;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb_o <= BLACK;
        end else begin
            rgb_o <= rgb_d; // one cycle behind scan_i
        end
    end

endmodule

`default_nettype wire

/* verilog/shooter_top.sv */
`default_nettype none

module shooter_top import video_pkg::*, game_pkg::*; #(
    parameter int GUN_V  = 4,
    parameter int SHOT_V = 7,
    parameter int N_OBS  = 10
) (
    input  wire         clk,
    input  wire         rst,
    input  wire scan_t  scan_i,
    input  wire keys_t  keys_i,
    output color_e      rgb_o,
    output status_t     status_o
);

    logic   frame_tick, play;
    logic   hit, miss;
    logic   gun_on, shot_on, obs_on;
    logic   shot_live;
    coord_t gun_x;
    scan_t  shot_pos;

    gun_ctrl #(.GUN_V(GUN_V)) i_gun (
        .clk, .rst, .frame_tick_i(frame_tick), .play_i(play), .keys_i,
        .scan_i, .gun_x_o(gun_x), .gun_on_o(gun_on)
    );

    shot_ctrl #(.SHOT_V(SHOT_V)) i_shot (
        .clk, .rst, .frame_tick_i(frame_tick), .play_i(play), .fire_i(keys_i.fire),
        .gun_x_i(gun_x), .hit_i(hit), .scan_i, .shot_pos_o(shot_pos),
        .shot_live_o(shot_live), .miss_o(miss), .shot_on_o(shot_on)
    );

    obstacle_row #(.N_OBS(N_OBS)) i_obs (
        .clk, .rst, .frame_tick_i(frame_tick), .play_i(play), .shot_pos_i(shot_pos),
        .shot_live_i(shot_live), .scan_i, .hit_o(hit), .obs_on_o(obs_on)
    );

    game_fsm i_fsm (
        .clk, .rst, .scan_i, .start_i(keys_i.start), .hit_i(hit), .miss_i(miss),
        .frame_tick_o(frame_tick), .play_o(play), .status_o
    );

    pixel_mux i_mux (
        .clk, .rst, .gun_on_i(gun_on), .shot_on_i(shot_on), .obs_on_i(obs_on),
        .game_over_i(status_o.game_over), .scan_i, .rgb_o
    );

endmodule

`default_nettype wire
